// File: include/id_settings.svh
//////////////////////////////////////////////////
// Build settings for the instruction ID tracker
// Pool size, ID width, retire ports and
// writeback ports
//////////////////////////////////////////////////

`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// Number of instruction IDs in the rotating pool
`define MAX_IDS 8

// Width of one ID, log2 of the pool size
`define LOG2_MAX_IDS 3

// Instructions that can retire in one cycle
`define RETIRE_PORTS 2

// Writeback ports reporting multicycle completion
`define WB_PORTS 1

`endif

// File: source/id_allocator.sv
//////////////////////////////////////////////////
// ID allocator
// PC, fetch and decode ID pointers
// Oldest pre-issue pointer, supplied as issue_id
// Fetched, pre-issue and post-issue counters
// In-flight total and pool availability
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "id_settings.svh"

module id_allocator
    import id_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          fetch_flush,
    input  logic          pc_id_assigned,
    input  logic          fetch_complete,
    input  logic          decode_advance,
    input  logic          instruction_issued,
    input  retire_count_t retire_count_next,
    output id_t           pc_id,
    output id_t           fetch_id,
    output id_t           decode_id,
    output id_t           issue_id,
    output logic          pc_id_available,
    output logic          decode_valid,
    output id_count_t     post_issue_count
);

    id_t       oldest_pre_issue_id;
    id_t       oldest_pre_issue_next;
    id_count_t fetched_count_neg;
    id_count_t pre_issue_count;
    id_count_t pre_issue_count_next;
    id_count_t post_issue_count_next;
    id_count_t inflight_count;

    //////////////////////////////////////////////////
    // ID pointers

    // Issue is in order, so the issued ID is always the oldest pre-issue one
    assign oldest_pre_issue_next = oldest_pre_issue_id + id_t'(instruction_issued);
    assign issue_id = oldest_pre_issue_id;

    always_ff @(posedge clk) begin
        if (rst) begin
            oldest_pre_issue_id <= '0;
        end else begin
            oldest_pre_issue_id <= oldest_pre_issue_next;
        end
    end

    // A flush rewinds the fetch side to the first unissued ID
    // Uses the next value so an issue in the flush cycle is not lost
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_id     <= '0;
            fetch_id  <= '0;
            decode_id <= '0;
        end else if (fetch_flush) begin
            pc_id     <= oldest_pre_issue_next;
            fetch_id  <= oldest_pre_issue_next;
            decode_id <= oldest_pre_issue_next;
        end else begin
            pc_id     <= pc_id + id_t'(pc_id_assigned);
            fetch_id  <= fetch_id + id_t'(fetch_complete);
            decode_id <= decode_id + id_t'(decode_advance);
        end
    end

    //////////////////////////////////////////////////
    // Occupancy counters

    // Kept negative, so the top bit means decode holds an instruction
    always_ff @(posedge clk) begin
        if (rst || fetch_flush) begin
            fetched_count_neg <= '0;
        end else begin
            fetched_count_neg <= fetched_count_neg + id_count_t'(decode_advance)
                - id_count_t'(fetch_complete);
        end
    end

    assign decode_valid = fetched_count_neg[`LOG2_MAX_IDS];

    // Pre-issue IDs are dropped on a flush
    assign pre_issue_count_next = pre_issue_count + id_count_t'(pc_id_assigned)
        - id_count_t'(instruction_issued);

    always_ff @(posedge clk) begin
        if (rst || fetch_flush) begin
            pre_issue_count <= '0;
        end else begin
            pre_issue_count <= pre_issue_count_next;
        end
    end

    // Post-issue IDs leave only by retiring
    assign post_issue_count_next = post_issue_count + id_count_t'(instruction_issued)
        - id_count_t'(retire_count_next);

    always_ff @(posedge clk) begin
        if (rst) begin
            post_issue_count <= '0;
        end else begin
            post_issue_count <= post_issue_count_next;
        end
    end

    // Registered total, top bit set once every ID is taken
    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_count <= '0;
        end else if (fetch_flush) begin
            inflight_count <= post_issue_count_next;
        end else begin
            inflight_count <= pre_issue_count_next + post_issue_count_next;
        end
    end

    assign pc_id_available = ~inflight_count[`LOG2_MAX_IDS];

endmodule

// File: source/id_pkg.sv
//////////////////////////////////////////////////
// Shared types for the instruction ID tracker
// ID, occupancy count and retire count widths
//////////////////////////////////////////////////

`include "id_settings.svh"

package id_pkg;

    // One instruction ID
    typedef logic [`LOG2_MAX_IDS-1:0] id_t;

    // Occupancy count, top bit set when the pool is full
    typedef logic [`LOG2_MAX_IDS:0] id_count_t;

    // Instructions retired in one cycle, 0 to RETIRE_PORTS
    typedef logic [$clog2(`RETIRE_PORTS+1)-1:0] retire_count_t;

endpackage

// File: source/id_tracker_top.sv
//////////////////////////////////////////////////
// Instruction ID tracker top level
// ID allocator, metadata tables, writeback
// wait memory and retire control
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "id_settings.svh"

module id_tracker_top
    import id_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    // Fetch
    input  logic                     pc_id_assigned,
    input  logic [31:0]              if_pc,
    input  logic                     fetch_complete,
    input  logic [31:0]              fetch_instruction,
    input  logic                     fetch_flush,
    output id_t                      pc_id,
    output id_t                      fetch_id,
    output logic                     pc_id_available,
    // Decode
    input  logic                     decode_advance,
    input  logic                     decode_uses_rd,
    input  logic [4:0]               decode_rd_addr,
    output id_t                      decode_id,
    output logic                     decode_valid,
    output logic [31:0]              decode_pc,
    output logic [31:0]              decode_instruction,
    // Issue
    input  logic                     instruction_issued,
    input  logic                     issue_waits_for_wb,
    output id_t                      issue_id,
    // Writeback
    input  logic [`WB_PORTS-1:0]     wb_valid,
    input  id_t                      wb_id [`WB_PORTS],
    // Retire
    input  logic                     retire_hold,
    output id_t                      retire_ids [`RETIRE_PORTS],
    output retire_count_t            retire_count,
    output logic [`RETIRE_PORTS-1:0] retire_port_valid,
    output logic                     retire_rd_valid,
    output id_t                      retire_rd_id
);

    localparam int WAIT_WRITE_PORTS = `WB_PORTS + 1;

    id_count_t                   post_issue_count;
    retire_count_t               retire_count_next;
    id_t                         retire_ids_next [`RETIRE_PORTS];
    logic [`RETIRE_PORTS-1:0]    retire_uses_rd;
    logic [`RETIRE_PORTS-1:0]    id_waiting;
    logic [WAIT_WRITE_PORTS-1:0] wait_toggle;
    id_t                         wait_toggle_addr [WAIT_WRITE_PORTS];

    id_allocator u_id_allocator (
        .clk                (clk),
        .rst                (rst),
        .fetch_flush        (fetch_flush),
        .pc_id_assigned     (pc_id_assigned),
        .fetch_complete     (fetch_complete),
        .decode_advance     (decode_advance),
        .instruction_issued (instruction_issued),
        .retire_count_next  (retire_count_next),
        .pc_id              (pc_id),
        .fetch_id           (fetch_id),
        .decode_id          (decode_id),
        .issue_id           (issue_id),
        .pc_id_available    (pc_id_available),
        .decode_valid       (decode_valid),
        .post_issue_count   (post_issue_count)
    );

    metadata_tables u_metadata_tables (
        .clk                (clk),
        .pc_id_assigned     (pc_id_assigned),
        .pc_id              (pc_id),
        .if_pc              (if_pc),
        .fetch_complete     (fetch_complete),
        .fetch_id           (fetch_id),
        .fetch_instruction  (fetch_instruction),
        .decode_advance     (decode_advance),
        .decode_id          (decode_id),
        .decode_uses_rd     (decode_uses_rd),
        .decode_rd_addr     (decode_rd_addr),
        .retire_ids_next    (retire_ids_next),
        .decode_pc          (decode_pc),
        .decode_instruction (decode_instruction),
        .retire_uses_rd     (retire_uses_rd)
    );

    //////////////////////////////////////////////////
    // Writeback wait tracking

    // Port 0 marks a multicycle issue, the rest clear on writeback
    assign wait_toggle[0]      = instruction_issued & issue_waits_for_wb;
    assign wait_toggle_addr[0] = issue_id;

    for (genvar i = 0; i < `WB_PORTS; i++) begin : gen_wb_toggle
        assign wait_toggle[i+1]      = wb_valid[i];
        assign wait_toggle_addr[i+1] = wb_id[i];
    end

    toggle_memory #(
        .WRITE_PORTS (WAIT_WRITE_PORTS),
        .READ_PORTS  (`RETIRE_PORTS)
    ) u_toggle_memory (
        .clk         (clk),
        .rst         (rst),
        .toggle      (wait_toggle),
        .toggle_addr (wait_toggle_addr),
        .read_addr   (retire_ids_next),
        .in_use      (id_waiting)
    );

    retire_control u_retire_control (
        .clk               (clk),
        .rst               (rst),
        .retire_hold       (retire_hold),
        .post_issue_count  (post_issue_count),
        .retire_uses_rd    (retire_uses_rd),
        .id_waiting        (id_waiting),
        .retire_ids_next   (retire_ids_next),
        .retire_ids        (retire_ids),
        .retire_count_next (retire_count_next),
        .retire_count      (retire_count),
        .retire_port_valid (retire_port_valid),
        .retire_rd_valid   (retire_rd_valid),
        .retire_rd_id      (retire_rd_id)
    );

endmodule

// File: source/metadata_tables.sv
//////////////////////////////////////////////////
// Per-ID metadata tables
// PC and instruction tables read by decode
// Uses-rd table read by the retire ports
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "id_settings.svh"

module metadata_tables
    import id_pkg::*;
(
    input  logic                     clk,
    input  logic                     pc_id_assigned,
    input  id_t                      pc_id,
    input  logic [31:0]              if_pc,
    input  logic                     fetch_complete,
    input  id_t                      fetch_id,
    input  logic [31:0]              fetch_instruction,
    input  logic                     decode_advance,
    input  id_t                      decode_id,
    input  logic                     decode_uses_rd,
    input  logic [4:0]               decode_rd_addr,
    input  id_t                      retire_ids_next [`RETIRE_PORTS],
    output logic [31:0]              decode_pc,
    output logic [31:0]              decode_instruction,
    output logic [`RETIRE_PORTS-1:0] retire_uses_rd
);

    logic [31:0]         pc_table [`MAX_IDS];
    logic [31:0]         instruction_table [`MAX_IDS];
    logic [`MAX_IDS-1:0] uses_rd_table;

    //////////////////////////////////////////////////
    // Table writes

    // PC captured when fetch takes the ID
    always_ff @(posedge clk) begin
        if (pc_id_assigned) begin
            pc_table[pc_id] <= if_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_complete) begin
            instruction_table[fetch_id] <= fetch_instruction;
        end
    end

    // Register zero is never a real destination
    always_ff @(posedge clk) begin
        if (decode_advance) begin
            uses_rd_table[decode_id] <= decode_uses_rd && (decode_rd_addr != 5'd0);
        end
    end

    //////////////////////////////////////////////////
    // Asynchronous reads

    assign decode_pc          = pc_table[decode_id];
    assign decode_instruction = instruction_table[decode_id];

    always_comb begin
        for (int i = 0; i < `RETIRE_PORTS; i++) begin
            retire_uses_rd[i] = uses_rd_table[retire_ids_next[i]];
        end
    end

endmodule

// File: source/retire_control.sv
//////////////////////////////////////////////////
// In-order retire control
// Retire ID pointers, one per port
// Retire selection with the single-rd rule
// Registered retire outputs
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "id_settings.svh"

module retire_control
    import id_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     retire_hold,
    input  id_count_t                post_issue_count,
    input  logic [`RETIRE_PORTS-1:0] retire_uses_rd,
    input  logic [`RETIRE_PORTS-1:0] id_waiting,
    output id_t                      retire_ids_next [`RETIRE_PORTS],
    output id_t                      retire_ids [`RETIRE_PORTS],
    output retire_count_t            retire_count_next,
    output retire_count_t            retire_count,
    output logic [`RETIRE_PORTS-1:0] retire_port_valid,
    output logic                     retire_rd_valid,
    output id_t                      retire_rd_id
);

    logic [`RETIRE_PORTS-1:0] id_is_post_issue;
    logic [`RETIRE_PORTS-1:0] retire_port_valid_next;
    logic                     contiguous_retire;
    logic                     retire_with_rd_found;
    id_t                      retire_rd_id_next;

    //////////////////////////////////////////////////
    // Retire ID pointers

    // Port i looks i entries past the oldest post-issue ID
    always_ff @(posedge clk) begin
        for (int i = 0; i < `RETIRE_PORTS; i++) begin
            if (rst) begin
                retire_ids_next[i] <= id_t'(i);
            end else begin
                retire_ids_next[i] <= retire_ids_next[i] + id_t'(retire_count_next);
            end
        end
    end

    //////////////////////////////////////////////////
    // Retire selection

    // The retiring block is contiguous from port 0
    // At most one rd writer per cycle, reported on retire_rd_id
    always_comb begin
        contiguous_retire    = 1'b1;
        retire_with_rd_found = 1'b0;
        retire_rd_id_next    = retire_ids_next[0];
        for (int i = 0; i < `RETIRE_PORTS; i++) begin
            id_is_post_issue[i] = post_issue_count > id_count_t'(i);
            retire_port_valid_next[i] = id_is_post_issue[i]
                && !id_waiting[i]
                && contiguous_retire
                && !(retire_uses_rd[i] && retire_with_rd_found)
                && !retire_hold;
            // First rd writer found wins the rd report
            if (retire_port_valid_next[i] && retire_uses_rd[i] && !retire_with_rd_found) begin
                retire_rd_id_next = retire_ids_next[i];
            end
            retire_with_rd_found = retire_with_rd_found
                | (retire_port_valid_next[i] & retire_uses_rd[i]);
            contiguous_retire = contiguous_retire & retire_port_valid_next[i];
        end
    end

    always_comb begin
        retire_count_next = '0;
        for (int i = 0; i < `RETIRE_PORTS; i++) begin
            retire_count_next = retire_count_next + retire_count_t'(retire_port_valid_next[i]);
        end
    end

    //////////////////////////////////////////////////
    // Registered outputs

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_count      <= '0;
            retire_port_valid <= '0;
            retire_rd_valid   <= 1'b0;
        end else begin
            retire_count      <= retire_count_next;
            retire_port_valid <= retire_port_valid_next;
            retire_rd_valid   <= retire_with_rd_found;
        end
    end

    // IDs travel alongside the valid bits
    always_ff @(posedge clk) begin
        retire_rd_id <= retire_rd_id_next;
        for (int i = 0; i < `RETIRE_PORTS; i++) begin
            retire_ids[i] <= retire_ids_next[i];
        end
    end

endmodule

// File: source/toggle_memory.sv
//////////////////////////////////////////////////
// One-bit in-use memory with several write ports
// One toggle bank per write port
// A location reads as in use when the banks XOR to one
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "id_settings.svh"

module toggle_memory
    import id_pkg::*;
#(
    parameter int WRITE_PORTS = 2,
    parameter int READ_PORTS  = 2
)
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [WRITE_PORTS-1:0] toggle,
    input  id_t                    toggle_addr [WRITE_PORTS],
    input  id_t                    read_addr [READ_PORTS],
    output logic [READ_PORTS-1:0]  in_use
);

    logic [`MAX_IDS-1:0] bank [WRITE_PORTS];

    // Each port only flips bits in its own bank, so ports never collide
    always_ff @(posedge clk) begin
        for (int w = 0; w < WRITE_PORTS; w++) begin
            if (rst) begin
                bank[w] <= '0;
            end else if (toggle[w]) begin
                bank[w][toggle_addr[w]] <= ~bank[w][toggle_addr[w]];
            end
        end
    end

    // Set on one port and clear on another cancel in the XOR
    always_comb begin
        for (int r = 0; r < READ_PORTS; r++) begin
            in_use[r] = 1'b0;
            for (int w = 0; w < WRITE_PORTS; w++) begin
                in_use[r] = in_use[r] ^ bank[w][read_addr[r]];
            end
        end
    end

endmodule

// File: tb.f
+incdir+include
source/id_pkg.sv
source/id_allocator.sv
source/metadata_tables.sv
source/toggle_memory.sv
source/retire_control.sv
source/id_tracker_top.sv
tb/id_tracker_checker.sv
tb/tb_id_tracker.sv

// File: tb/id_tracker_checker.sv
//////////////////////////////////////////////////
// Protocol checker for the instruction ID tracker
// Fetch and decode handshake rules
// Retire count consistency
// Bound into the tracker top level
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "id_settings.svh"

module id_tracker_checker
    import id_pkg::*;
(
    input logic                     clk,
    input logic                     rst,
    input logic                     pc_id_assigned,
    input logic                     pc_id_available,
    input logic                     decode_advance,
    input logic                     decode_valid,
    input retire_count_t            retire_count,
    input logic [`RETIRE_PORTS-1:0] retire_port_valid
);

    // Read by the testbench at the end of the run
    int failure_count;

    initial failure_count = 0;

    // Fetch takes an ID only from a pool with room
    assign_needs_room : assert property (@(posedge clk) disable iff (rst)
        pc_id_assigned |-> pc_id_available)
    else begin
        $error("ID assigned while the pool was full");
        failure_count++;
    end

    // Decode moves on only with an instruction in hand
    advance_needs_valid : assert property (@(posedge clk) disable iff (rst)
        decode_advance |-> decode_valid)
    else begin
        $error("decode advanced without a valid instruction");
        failure_count++;
    end

    retire_count_bounded : assert property (@(posedge clk) disable iff (rst)
        retire_count <= retire_count_t'(`RETIRE_PORTS))
    else begin
        $error("retire count above the number of retire ports");
        failure_count++;
    end

    // Count and valid bits describe the same retire group
    retire_count_matches_ports : assert property (@(posedge clk) disable iff (rst)
        int'(retire_count) == $countones(retire_port_valid))
    else begin
        $error("retire count differs from the set retire port bits");
        failure_count++;
    end

endmodule

bind id_tracker_top id_tracker_checker u_id_tracker_checker (
    .clk               (clk),
    .rst               (rst),
    .pc_id_assigned    (pc_id_assigned),
    .pc_id_available   (pc_id_available),
    .decode_advance    (decode_advance),
    .decode_valid      (decode_valid),
    .retire_count      (retire_count),
    .retire_port_valid (retire_port_valid)
);

// File: tb/tb_id_tracker.sv
//////////////////////////////////////////////////
// Testbench for the instruction ID tracker
// Clock, reset and LFSR stimulus source
// Reference model queues for decode and retire
// Directed tests for fetch, pool limit, flush,
// retire rules and writeback wait
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "id_settings.svh"

module tb_id_tracker
    import id_pkg::*;
();

    localparam int WAIT_LIMIT = 50;

    logic                     clk;
    logic                     rst;
    logic                     pc_id_assigned;
    logic [31:0]              if_pc;
    logic                     fetch_complete;
    logic [31:0]              fetch_instruction;
    logic                     fetch_flush;
    id_t                      pc_id;
    id_t                      fetch_id;
    logic                     pc_id_available;
    logic                     decode_advance;
    logic                     decode_uses_rd;
    logic [4:0]               decode_rd_addr;
    id_t                      decode_id;
    logic                     decode_valid;
    logic [31:0]              decode_pc;
    logic [31:0]              decode_instruction;
    logic                     instruction_issued;
    logic                     issue_waits_for_wb;
    id_t                      issue_id;
    logic [`WB_PORTS-1:0]     wb_valid;
    id_t                      wb_id [`WB_PORTS];
    logic                     retire_hold;
    id_t                      retire_ids [`RETIRE_PORTS];
    retire_count_t            retire_count;
    logic [`RETIRE_PORTS-1:0] retire_port_valid;
    logic                     retire_rd_valid;
    id_t                      retire_rd_id;

    // Model state for fetched but undecoded and issued but unretired instructions
    int          dec_id_q [$];
    logic [31:0] dec_pc_q [$];
    logic [31:0] dec_instr_q [$];
    int          ret_id_q [$];
    logic        ret_rd_q [$];
    int          next_pc_id;
    int          next_issue_id;
    logic [15:0] lfsr_state;

    id_tracker_top u_id_tracker_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Helpers

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] random_bits(input int width);
        logic [31:0] word;
        word = '0;
        for (int b = 0; b < width; b++) begin
            word = {word[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        end
        return word;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic set_hold(input logic value);
        @(posedge clk);
        retire_hold <= value;
    endtask

    // Assign one ID and fetch it in the same cycle, one instruction at a time
    task automatic assign_and_fetch(input int count);
        logic [31:0] pc;
        logic [31:0] instr;
        for (int i = 0; i < count; i++) begin
            pc    = random_bits(30) << 2;
            instr = random_bits(32);
            @(negedge clk);
            check_value("pc_id_available", pc_id_available, 1);
            check_value("pc_id", pc_id, next_pc_id);
            check_value("fetch_id", fetch_id, next_pc_id);
            @(posedge clk);
            pc_id_assigned    <= 1'b1;
            if_pc             <= pc;
            fetch_complete    <= 1'b1;
            fetch_instruction <= instr;
            @(posedge clk);
            pc_id_assigned <= 1'b0;
            fetch_complete <= 1'b0;
            dec_id_q.push_back(next_pc_id);
            dec_pc_q.push_back(pc);
            dec_instr_q.push_back(instr);
            next_pc_id = (next_pc_id + 1) % `MAX_IDS;
        end
    endtask

    // Decode the oldest fetched instruction and issue it in the same cycle
    task automatic decode_and_issue(input logic uses_rd, input int rd_addr, input logic waits);
        int timeout;
        timeout = 0;
        @(negedge clk);
        while (!decode_valid) begin
            timeout++;
            if (timeout > WAIT_LIMIT) begin
                abort_run("decode_valid never rose for a fetched instruction");
            end
            @(negedge clk);
        end
        if (dec_id_q.size() == 0) begin
            abort_run("decode shows an instruction that was never fetched");
        end
        check_value("decode_id", decode_id, dec_id_q[0]);
        check_value("decode_pc", decode_pc, dec_pc_q[0]);
        check_value("decode_instruction", decode_instruction, dec_instr_q[0]);
        check_value("issue_id", issue_id, next_issue_id);
        @(posedge clk);
        decode_advance     <= 1'b1;
        decode_uses_rd     <= uses_rd;
        decode_rd_addr     <= 5'(rd_addr);
        instruction_issued <= 1'b1;
        issue_waits_for_wb <= waits;
        @(posedge clk);
        decode_advance     <= 1'b0;
        instruction_issued <= 1'b0;
        issue_waits_for_wb <= 1'b0;
        // Register zero is no destination
        ret_id_q.push_back(dec_id_q.pop_front());
        ret_rd_q.push_back(uses_rd && rd_addr != 0);
        void'(dec_pc_q.pop_front());
        void'(dec_instr_q.pop_front());
        next_issue_id = (next_issue_id + 1) % `MAX_IDS;
    endtask

    task automatic check_no_retire(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_value("retire_count", retire_count, 0);
            check_value("retire_port_valid", retire_port_valid, 0);
        end
    endtask

    // Groups are contiguous from port 0 with at most one rd writer
    task automatic drain_retires(input int wait_limit);
        int                       timeout;
        int                       count;
        int                       rd_port;
        logic [`RETIRE_PORTS-1:0] valid_bits;
        timeout = 0;
        @(negedge clk);
        while (retire_port_valid == '0) begin
            timeout++;
            if (timeout >= wait_limit) begin
                abort_run("issued instructions did not start retiring in time");
            end
            @(negedge clk);
        end
        while (ret_id_q.size() > 0) begin
            count      = 0;
            rd_port    = -1;
            valid_bits = '0;
            while (count < `RETIRE_PORTS && count < ret_id_q.size()
                   && !(rd_port >= 0 && ret_rd_q[count])) begin
                if (ret_rd_q[count]) begin
                    rd_port = count;
                end
                valid_bits[count] = 1'b1;
                count++;
            end
            check_value("retire_count", retire_count, count);
            check_value("retire_port_valid", retire_port_valid, valid_bits);
            check_value("retire_rd_valid", retire_rd_valid, rd_port >= 0);
            if (rd_port >= 0) begin
                check_value("retire_rd_id", retire_rd_id, ret_id_q[rd_port]);
            end
            for (int i = 0; i < count; i++) begin
                check_value($sformatf("retire_ids[%0d]", i), retire_ids[i], ret_id_q[i]);
            end
            for (int i = 0; i < count; i++) begin
                void'(ret_id_q.pop_front());
                void'(ret_rd_q.pop_front());
            end
            @(negedge clk);
        end
        check_value("retire_port_valid", retire_port_valid, 0);
    endtask

    //////////////////////////////////////////////////
    // Directed tests

    task automatic reset_values();
        @(negedge clk);
        check_value("pc_id_available", pc_id_available, 1);
        check_value("decode_valid", decode_valid, 0);
        check_value("retire_count", retire_count, 0);
        check_value("retire_port_valid", retire_port_valid, 0);
        check_value("retire_rd_valid", retire_rd_valid, 0);
    endtask

    task automatic fetch_decode_order();
        set_hold(1'b1);
        assign_and_fetch(5);
        for (int i = 0; i < 5; i++) begin
            decode_and_issue(1'b0, 0, 1'b0);
        end
        set_hold(1'b0);
        drain_retires(WAIT_LIMIT);
        set_hold(1'b1);
    endtask

    task automatic pool_backpressure();
        int timeout;
        assign_and_fetch(`MAX_IDS);
        @(negedge clk);
        check_value("pc_id_available", pc_id_available, 0);
        for (int i = 0; i < `MAX_IDS; i++) begin
            decode_and_issue(1'b0, 0, 1'b0);
        end
        // Issued but unretired IDs still fill the pool
        @(negedge clk);
        check_value("pc_id_available", pc_id_available, 0);
        set_hold(1'b0);
        drain_retires(WAIT_LIMIT);
        timeout = 0;
        while (!pc_id_available) begin
            timeout++;
            if (timeout > WAIT_LIMIT) begin
                abort_run("pc_id_available stayed low after the pool drained");
            end
            @(negedge clk);
        end
        set_hold(1'b1);
    endtask

    task automatic flush_rewind();
        assign_and_fetch(4);
        decode_and_issue(1'b0, 0, 1'b0);
        decode_and_issue(1'b0, 0, 1'b0);
        @(posedge clk);
        fetch_flush <= 1'b1;
        @(posedge clk);
        fetch_flush <= 1'b0;
        @(negedge clk);
        check_value("decode_valid", decode_valid, 0);
        check_value("pc_id", pc_id, next_issue_id);
        check_value("fetch_id", fetch_id, next_issue_id);
        check_value("decode_id", decode_id, next_issue_id);
        // Fetch restarts from the first unissued ID
        dec_id_q.delete();
        dec_pc_q.delete();
        dec_instr_q.delete();
        next_pc_id = next_issue_id;
        assign_and_fetch(1);
        decode_and_issue(1'b0, 0, 1'b0);
        set_hold(1'b0);
        drain_retires(WAIT_LIMIT);
        set_hold(1'b1);
    endtask

    task automatic retire_grouping();
        assign_and_fetch(6);
        decode_and_issue(1'b0, 0, 1'b0);
        decode_and_issue(1'b0, 0, 1'b0);
        decode_and_issue(1'b1, 5, 1'b0);
        decode_and_issue(1'b1, 6, 1'b0);
        decode_and_issue(1'b1, 0, 1'b0);
        decode_and_issue(1'b1, 7, 1'b0);
        check_no_retire(4);
        set_hold(1'b0);
        drain_retires(WAIT_LIMIT);
        set_hold(1'b1);
    endtask

    task automatic writeback_ordering();
        int multicycle_id;
        assign_and_fetch(3);
        multicycle_id = next_issue_id;
        decode_and_issue(1'b1, 3, 1'b1);
        decode_and_issue(1'b0, 0, 1'b0);
        decode_and_issue(1'b0, 0, 1'b0);
        // Hold released while the oldest still waits for its result
        set_hold(1'b0);
        check_no_retire(5);
        @(posedge clk);
        wb_valid[0] <= 1'b1;
        wb_id[0]    <= id_t'(multicycle_id);
        @(posedge clk);
        wb_valid[0] <= 1'b0;
        @(negedge clk);
        check_value("retire_port_valid", retire_port_valid, 0);
        drain_retires(1);
        set_hold(1'b1);
    endtask

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        lfsr_state         = 16'd81;
        next_pc_id         = 0;
        next_issue_id      = 0;
        rst                = 1'b1;
        pc_id_assigned     = 1'b0;
        if_pc              = '0;
        fetch_complete     = 1'b0;
        fetch_instruction  = '0;
        fetch_flush        = 1'b0;
        decode_advance     = 1'b0;
        decode_uses_rd     = 1'b0;
        decode_rd_addr     = '0;
        instruction_issued = 1'b0;
        issue_waits_for_wb = 1'b0;
        wb_valid           = '0;
        wb_id[0]           = '0;
        retire_hold        = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        reset_values();
        fetch_decode_order();
        pool_backpressure();
        flush_rewind();
        retire_grouping();
        writeback_ordering();

        repeat (2) @(posedge clk);
        if (u_id_tracker_top.u_id_tracker_checker.failure_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("The protocol checker reported assertion failures");
            $display("Simulation failed");
            $fatal(1, "Assertion failures");
        end
    end

endmodule
